// ==== mem_stage_pkg.sv ====
// ==========================================================
// Shared types for the RV32 memory-access stage
// ==========================================================

package mem_stage_pkg;

  // Data word for register values, memory data and results
  typedef logic [31:0] word_t;

  // Byte address as produced by the ALU
  typedef logic [31:0] addr_t;

  // One write strobe bit per byte lane
  typedef logic [3:0] strb_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Load/store size and sign field taken from the instruction
  typedef logic [2:0] funct3_t;

  // Byte position inside a 32-bit word
  typedef logic [1:0] byte_off_t;

  // ==========================================================
  // Load/store size encodings
  // ==========================================================

  // Low two bits give the access size
  // Bit 2 set selects zero extension on loads
  localparam funct3_t LS_B  = 3'd0;
  localparam funct3_t LS_H  = 3'd1;
  localparam funct3_t LS_W  = 3'd2;
  localparam funct3_t LS_BU = 3'd4;
  localparam funct3_t LS_HU = 3'd5;

endpackage

// ==== store_formatter.sv ====
module store_formatter (
  input  mem_stage_pkg::word_t     store_data_i,
  input  mem_stage_pkg::byte_off_t offset_i,
  input  mem_stage_pkg::funct3_t   funct3_i,
  output mem_stage_pkg::word_t     wdata_o,
  output mem_stage_pkg::strb_t     wstrb_o
);

  // Size only, sign bit dropped so unsigned codes fold onto signed ones
  mem_stage_pkg::funct3_t size_code;

  assign size_code = {1'b0, funct3_i[1:0]};

  // ==========================================================
  // Lane placement and strobes
  // ==========================================================

  always_comb begin
    case (size_code)
      mem_stage_pkg::LS_B: begin
        // Byte copied to every lane, strobe picks the real one
        wdata_o = {4{store_data_i[7:0]}};
        wstrb_o = mem_stage_pkg::strb_t'(4'b0001 << offset_i);
      end
      mem_stage_pkg::LS_H: begin
        // Halfword copied to both halves
        wdata_o = {2{store_data_i[15:0]}};
        // Offset bit 0 is known clear here
        if (offset_i[1]) begin
          wstrb_o = 4'b1100;
        end else begin
          wstrb_o = 4'b0011;
        end
      end
      default: begin
        // Full word, all lanes written
        wdata_o = store_data_i;
        wstrb_o = 4'b1111;
      end
    endcase
  end

endmodule

// ==== load_formatter.sv ====
module load_formatter (
  input  mem_stage_pkg::word_t     rdata_i,
  input  mem_stage_pkg::byte_off_t offset_i,
  input  mem_stage_pkg::funct3_t   funct3_i,
  output mem_stage_pkg::word_t     ld_data_o
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // ==========================================================
  // Lane selection
  // ==========================================================

  // Addressed byte out of the read word
  always_comb begin
    case (offset_i)
      2'd0:    sel_byte = rdata_i[7:0];
      2'd1:    sel_byte = rdata_i[15:8];
      2'd2:    sel_byte = rdata_i[23:16];
      default: sel_byte = rdata_i[31:24];
    endcase
  end

  // Upper or lower halfword
  assign sel_half = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ==========================================================
  // Extension
  // ==========================================================

  always_comb begin
    case (funct3_i)
      // Signed byte
      mem_stage_pkg::LS_B:  ld_data_o = {{24{sel_byte[7]}}, sel_byte};
      // Unsigned byte
      mem_stage_pkg::LS_BU: ld_data_o = {24'd0, sel_byte};
      // Signed halfword
      mem_stage_pkg::LS_H:  ld_data_o = {{16{sel_half[15]}}, sel_half};
      // Unsigned halfword
      mem_stage_pkg::LS_HU: ld_data_o = {16'd0, sel_half};
      // Word passes through as read
      default:              ld_data_o = rdata_i;
    endcase
  end

endmodule

// ==== mem_access_ctrl.sv ====
module mem_access_ctrl (
  input  logic                   in_valid_i,
  input  logic                   in_ready_i,
  input  logic                   is_load_i,
  input  logic                   is_store_i,
  input  mem_stage_pkg::funct3_t funct3_i,
  input  mem_stage_pkg::addr_t   addr_i,
  output logic                   accept_o,
  output logic                   misalign_o,
  output logic                   dmem_ren_o,
  output mem_stage_pkg::addr_t   dmem_raddr_o,
  output logic                   dmem_we_o,
  output mem_stage_pkg::addr_t   dmem_waddr_o
);

  // Access size with the sign bit masked off
  mem_stage_pkg::funct3_t size_code;
  logic                   is_mem;
  mem_stage_pkg::addr_t   word_addr;

  // Transfer from EX happens only with both sides ready
  assign accept_o = in_valid_i && in_ready_i;

  // ==========================================================
  // Misalignment check
  // ==========================================================

  assign size_code = {1'b0, funct3_i[1:0]};
  assign is_mem    = is_load_i || is_store_i;

  always_comb begin
    misalign_o = 1'b0;
    // ALU operations never trap here
    if (is_mem) begin
      case (size_code)
        mem_stage_pkg::LS_H: misalign_o = addr_i[0];
        mem_stage_pkg::LS_W: misalign_o = |addr_i[1:0];
        // Bytes are always aligned
        default:             misalign_o = 1'b0;
      endcase
    end
  end

  // ==========================================================
  // Data memory port
  // ==========================================================

  // Enables fire once, in the transfer cycle, and never on a trap
  assign dmem_ren_o = accept_o && is_load_i && !misalign_o;
  assign dmem_we_o  = accept_o && is_store_i && !misalign_o;

  // Memory is word addressed, lanes come from the strobes
  assign word_addr    = {addr_i[31:2], 2'b00};
  assign dmem_raddr_o = word_addr;
  assign dmem_waddr_o = word_addr;

endmodule

// ==== mem_wb_reg.sv ====
module mem_wb_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    accept_i,
  input  logic                    wb_ready_i,
  output logic                    in_ready_o,
  input  logic                    misalign_i,
  input  logic                    is_load_i,
  input  logic                    reg_write_i,
  input  mem_stage_pkg::reg_idx_t rd_i,
  input  mem_stage_pkg::word_t    alu_result_i,
  input  mem_stage_pkg::word_t    ld_data_i,
  output logic                    wb_valid_o,
  output logic                    wb_reg_write_o,
  output mem_stage_pkg::reg_idx_t wb_rd_o,
  output mem_stage_pkg::word_t    wb_result_o,
  output logic                    wb_trap_o
);

  // Value headed for the result register
  mem_stage_pkg::word_t result_d;

  // Empty or draining this cycle, so a new entry fits
  assign in_ready_o = !wb_valid_o || wb_ready_i;

  // Loads write back the formatted data, all else the ALU value
  assign result_d = is_load_i ? ld_data_i : alu_result_i;

  // ==========================================================
  // Control part
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_reg_write_o <= 1'b0;
      wb_trap_o      <= 1'b0;
    end else if (accept_i) begin
      wb_valid_o     <= 1'b1;
      // A trapped access must not touch the register file
      wb_reg_write_o <= reg_write_i && !misalign_i;
      wb_trap_o      <= misalign_i;
    end else if (in_ready_o) begin
      // Bubble, nothing new behind the drained entry
      wb_valid_o     <= 1'b0;
      wb_reg_write_o <= 1'b0;
      wb_trap_o      <= 1'b0;
    end
  end

  // ==========================================================
  // Payload part
  // ==========================================================

  // Only meaningful while wb_valid_o is high
  always_ff @(posedge clk) begin
    if (accept_i) begin
      wb_rd_o     <= rd_i;
      wb_result_o <= result_d;
    end
  end

endmodule

// ==== mem_stage_top.sv ====
module mem_stage_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // From execute
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     is_load_i,
  input  logic                     is_store_i,
  input  logic                     reg_write_i,
  input  mem_stage_pkg::funct3_t   funct3_i,
  input  mem_stage_pkg::reg_idx_t  rd_i,
  input  mem_stage_pkg::addr_t     alu_result_i,
  input  mem_stage_pkg::word_t     store_data_i,
  // Data memory
  output logic                     dmem_ren_o,
  output mem_stage_pkg::addr_t     dmem_raddr_o,
  input  mem_stage_pkg::word_t     dmem_rdata_i,
  output logic                     dmem_we_o,
  output mem_stage_pkg::addr_t     dmem_waddr_o,
  output mem_stage_pkg::word_t     dmem_wdata_o,
  output mem_stage_pkg::strb_t     dmem_wstrb_o,
  // To write-back
  output logic                     wb_valid_o,
  input  logic                     wb_ready_i,
  output logic                     wb_reg_write_o,
  output mem_stage_pkg::reg_idx_t  wb_rd_o,
  output mem_stage_pkg::word_t     wb_result_o,
  output logic                     wb_trap_o
);

  logic                     accept;
  logic                     misalign;
  mem_stage_pkg::byte_off_t byte_off;
  mem_stage_pkg::word_t     ld_data;

  // Low address bits pick the lane for both formatters
  assign byte_off = alu_result_i[1:0];

  // ==========================================================
  // Access control and memory port
  // ==========================================================

  mem_access_ctrl u_access_ctrl (
    .in_valid_i   (in_valid_i),
    .in_ready_i   (in_ready_o),
    .is_load_i    (is_load_i),
    .is_store_i   (is_store_i),
    .funct3_i     (funct3_i),
    .addr_i       (alu_result_i),
    .accept_o     (accept),
    .misalign_o   (misalign),
    .dmem_ren_o   (dmem_ren_o),
    .dmem_raddr_o (dmem_raddr_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_waddr_o (dmem_waddr_o)
  );

  // Store lanes and strobes
  store_formatter u_store_fmt (
    .store_data_i (store_data_i),
    .offset_i     (byte_off),
    .funct3_i     (funct3_i),
    .wdata_o      (dmem_wdata_o),
    .wstrb_o      (dmem_wstrb_o)
  );

  // Read word arrives in the same cycle
  load_formatter u_load_fmt (
    .rdata_i   (dmem_rdata_i),
    .offset_i  (byte_off),
    .funct3_i  (funct3_i),
    .ld_data_o (ld_data)
  );

  // ==========================================================
  // MEM/WB register
  // ==========================================================

  mem_wb_reg u_mem_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .wb_ready_i     (wb_ready_i),
    .in_ready_o     (in_ready_o),
    .misalign_i     (misalign),
    .is_load_i      (is_load_i),
    .reg_write_i    (reg_write_i),
    .rd_i           (rd_i),
    .alu_result_i   (alu_result_i),
    .ld_data_i      (ld_data),
    .wb_valid_o     (wb_valid_o),
    .wb_reg_write_o (wb_reg_write_o),
    .wb_rd_o        (wb_rd_o),
    .wb_result_o    (wb_result_o),
    .wb_trap_o      (wb_trap_o)
  );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk_o
);

  // Free-running clock, 20 time units per period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

endmodule

// ==== mem_stage_props.sv ====
module mem_stage_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_valid_i,
  input logic                    in_ready_o,
  input logic                    dmem_ren_o,
  input logic                    dmem_we_o,
  input logic                    wb_valid_o,
  input logic                    wb_ready_i,
  input logic                    wb_reg_write_o,
  input mem_stage_pkg::reg_idx_t wb_rd_o,
  input mem_stage_pkg::word_t    wb_result_o,
  input logic                    wb_trap_o
);

  // Stalled write-back entry keeps every field
  property stall_holds_outputs;
    @(posedge clk) disable iff (!rst_n)
      (wb_valid_o && !wb_ready_i) |=>
        (wb_valid_o && $stable(wb_reg_write_o) && $stable(wb_rd_o) &&
         $stable(wb_result_o) && $stable(wb_trap_o));
  endproperty

  a_stall_hold: assert property (stall_holds_outputs)
    else $error("wb outputs changed while the sink was stalled");

  // Memory is touched only in an input transfer cycle
  a_enable_on_xfer: assert property (@(posedge clk) disable iff (!rst_n)
      (dmem_ren_o || dmem_we_o) |-> (in_valid_i && in_ready_o))
    else $error("memory enable high without an input transfer");

  a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
      !(dmem_ren_o && dmem_we_o))
    else $error("read and write enables high in the same cycle");

endmodule

bind mem_stage_top mem_stage_props u_props (
  .clk(clk), .rst_n(rst_n), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
  .dmem_ren_o(dmem_ren_o), .dmem_we_o(dmem_we_o), .wb_valid_o(wb_valid_o),
  .wb_ready_i(wb_ready_i), .wb_reg_write_o(wb_reg_write_o), .wb_rd_o(wb_rd_o),
  .wb_result_o(wb_result_o), .wb_trap_o(wb_trap_o)
);

// ==== mem_stage_tb.sv ====
module mem_stage_tb;

  localparam int NUM_INSTR     = 400;
  localparam int MEM_WORDS     = 16;
  localparam int WATCHDOG_TIME = NUM_INSTR * 20 * 8;

  typedef struct packed {
    logic        trap;
    logic        reg_write;
    logic [4:0]  rd;
    logic [31:0] result;
  } wb_entry_t;

  logic clk, rst_n, in_valid_i, in_ready_o, is_load_i, is_store_i, reg_write_i;
  logic dmem_ren_o, dmem_we_o, wb_valid_o, wb_ready_i, wb_reg_write_o, wb_trap_o;
  mem_stage_pkg::funct3_t   funct3_i;
  mem_stage_pkg::reg_idx_t  rd_i, wb_rd_o;
  mem_stage_pkg::addr_t     alu_result_i, dmem_raddr_o, dmem_waddr_o;
  mem_stage_pkg::word_t     store_data_i, dmem_rdata_i, dmem_wdata_o, wb_result_o;
  mem_stage_pkg::strb_t     dmem_wstrb_o;

  // Memory seen by the DUT and the shadow copy kept by the model
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] model_mem [MEM_WORDS];
  wb_entry_t   exp_q [$];
  int          err_count = 0;
  int          check_count = 0;
  logic        in_xfer_seen = 1'b0;
  logic        prev_in_xfer = 1'b0;
  logic        was_stalled = 1'b0;
  wb_entry_t   held;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  mem_stage_top UUT (
    .clk(clk), .rst_n(rst_n), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .is_load_i(is_load_i), .is_store_i(is_store_i), .reg_write_i(reg_write_i),
    .funct3_i(funct3_i), .rd_i(rd_i), .alu_result_i(alu_result_i),
    .store_data_i(store_data_i), .dmem_ren_o(dmem_ren_o), .dmem_raddr_o(dmem_raddr_o),
    .dmem_rdata_i(dmem_rdata_i), .dmem_we_o(dmem_we_o), .dmem_waddr_o(dmem_waddr_o),
    .dmem_wdata_o(dmem_wdata_o), .dmem_wstrb_o(dmem_wstrb_o), .wb_valid_o(wb_valid_o),
    .wb_ready_i(wb_ready_i), .wb_reg_write_o(wb_reg_write_o), .wb_rd_o(wb_rd_o),
    .wb_result_o(wb_result_o), .wb_trap_o(wb_trap_o)
  );

  // ==========================================================
  // Data memory with combinational read and strobed write
  // ==========================================================

  assign dmem_rdata_i = mem[dmem_raddr_o[5:2]];

  always @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (dmem_we_o && dmem_wstrb_o[lane]) begin
        mem[dmem_waddr_o[5:2]][8*lane +: 8] <= dmem_wdata_o[8*lane +: 8];
      end
    end
  end

  // ==========================================================
  // Reference model
  // ==========================================================

  // Start pattern, every byte tied to its word address
  function automatic logic [31:0] fill_word(int idx);
    return {8'(idx * 37 + 200), 8'(idx * 11 + 3), 8'(~idx), 8'(idx * 5 + 128)};
  endfunction

  function automatic logic is_misaligned(logic [2:0] f3, logic [1:0] off);
    if (f3[1:0] == 2'd1) return off[0];
    if (f3[1:0] == 2'd2) return off != 2'd0;
    return 1'b0;
  endfunction

  // Shift the lane down, then extend by size and sign
  function automatic logic [31:0] expect_load(logic [31:0] word, logic [1:0] off,
                                              logic [2:0] f3);
    logic [31:0] shifted;
    shifted = word >> (8 * off);
    if (f3[1:0] == 2'd0) return f3[2] ? {24'd0, shifted[7:0]} :
                                        {{24{shifted[7]}}, shifted[7:0]};
    if (f3[1:0] == 2'd1) return f3[2] ? {16'd0, shifted[15:0]} :
                                        {{16{shifted[15]}}, shifted[15:0]};
    return word;
  endfunction

  // Byte k of the data goes to byte offset+k of the word
  task automatic apply_store(logic [31:0] addr, logic [2:0] f3, logic [31:0] data);
    int nbytes;
    nbytes = 1 << f3[1:0];
    for (int k = 0; k < nbytes; k++) begin
      model_mem[addr[5:2]][8*(int'(addr[1:0]) + k) +: 8] = data[8*k +: 8];
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // ==========================================================
  // Monitor sampled at the falling edge
  // ==========================================================

  task automatic monitor_cycle();
    wb_entry_t exp;
    logic      mis;
    logic      in_xfer;
    // Stalled outputs must match what was held a cycle ago
    if (was_stalled) begin
      check_value("wb_valid_o", 32'(wb_valid_o), 32'd1);
      check_value("wb_reg_write_o", 32'(wb_reg_write_o), 32'(held.reg_write));
      check_value("wb_rd_o", 32'(wb_rd_o), 32'(held.rd));
      check_value("wb_result_o", wb_result_o, held.result);
      check_value("wb_trap_o", 32'(wb_trap_o), 32'(held.trap));
    end
    // One cycle from input transfer to write-back valid
    if (prev_in_xfer) check_value("wb_valid_o", 32'(wb_valid_o), 32'd1);
    check_value("in_ready_o", 32'(in_ready_o), 32'(!wb_valid_o || wb_ready_i));
    if (wb_valid_o && wb_ready_i) begin
      assert (exp_q.size() != 0) else begin
        err_count++;
        $display("Write-back transfer with no instruction outstanding");
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        check_value("wb_trap_o", 32'(wb_trap_o), 32'(exp.trap));
        check_value("wb_reg_write_o", 32'(wb_reg_write_o), 32'(exp.reg_write));
        check_value("wb_rd_o", 32'(wb_rd_o), 32'(exp.rd));
        if (!exp.trap) check_value("wb_result_o", wb_result_o, exp.result);
      end
    end
    in_xfer = in_valid_i && in_ready_o;
    mis = (is_load_i || is_store_i) && is_misaligned(funct3_i, alu_result_i[1:0]);
    check_value("dmem_ren_o", 32'(dmem_ren_o), 32'(in_xfer && is_load_i && !mis));
    check_value("dmem_we_o", 32'(dmem_we_o), 32'(in_xfer && is_store_i && !mis));
    // Word address on whichever port is enabled
    if (dmem_ren_o) check_value("dmem_raddr_o", dmem_raddr_o, {alu_result_i[31:2], 2'b00});
    if (dmem_we_o) check_value("dmem_waddr_o", dmem_waddr_o, {alu_result_i[31:2], 2'b00});
    if (in_xfer) begin
      exp.trap      = mis;
      exp.reg_write = reg_write_i && !mis;
      exp.rd        = rd_i;
      exp.result    = is_load_i ?
        expect_load(model_mem[alu_result_i[5:2]], alu_result_i[1:0], funct3_i) :
        alu_result_i;
      exp_q.push_back(exp);
      if (is_store_i && !mis) apply_store(alu_result_i, funct3_i, store_data_i);
    end
    in_xfer_seen = in_xfer;
    prev_in_xfer = in_xfer;
    was_stalled  = wb_valid_o && !wb_ready_i;
    held = {wb_trap_o, wb_reg_write_o, wb_rd_o, wb_result_o};
  endtask

  always @(negedge clk) begin
    if (rst_n) monitor_cycle();
  end

  // ==========================================================
  // Stimulus
  // ==========================================================

  // Steady ready first, then random back-pressure
  function automatic logic pick_ready(int i);
    if (i < 100) return 1'b1;
    return $urandom_range(0, 3) != 0;
  endfunction

  task automatic make_instruction();
    int          kind;
    logic [2:0]  f3;
    logic [31:0] addr;
    kind = $urandom_range(0, 2);
    case ($urandom_range(0, 4))
      0:       f3 = mem_stage_pkg::LS_B;
      1:       f3 = mem_stage_pkg::LS_H;
      2:       f3 = mem_stage_pkg::LS_W;
      3:       f3 = mem_stage_pkg::LS_BU;
      default: f3 = mem_stage_pkg::LS_HU;
    endcase
    addr = $urandom;
    // Mostly natural alignment so loads see stored data
    if ($urandom_range(0, 3) != 0) begin
      if (f3[1:0] == 2'd1) addr[0] = 1'b0;
      if (f3[1:0] == 2'd2) addr[1:0] = 2'b00;
    end
    is_load_i    = (kind == 0);
    is_store_i   = (kind == 1);
    reg_write_i  = (kind == 0) || ((kind == 2) && ($urandom_range(0, 1) == 1));
    funct3_i     = f3;
    rd_i         = mem_stage_pkg::reg_idx_t'($urandom);
    alu_result_i = addr;
    store_data_i = $urandom;
  endtask

  initial begin
    void'($urandom(32'h9b3d_dd5d));
    {in_valid_i, is_load_i, is_store_i, reg_write_i, wb_ready_i} = '0;
    funct3_i = '0;
    rd_i = '0;
    alu_result_i = '0;
    store_data_i = '0;
    for (int idx = 0; idx < MEM_WORDS; idx++) begin
      mem[idx] <= fill_word(idx);
      model_mem[idx] = fill_word(idx);
    end
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'd0);
    check_value("wb_reg_write_o", 32'(wb_reg_write_o), 32'd0);
    check_value("wb_trap_o", 32'(wb_trap_o), 32'd0);
    check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_INSTR; i++) begin
      // Occasional idle cycle on the input side
      if ($urandom_range(0, 7) == 0) begin
        in_valid_i = 1'b0;
        @(posedge clk);
        #1 wb_ready_i = pick_ready(i);
      end
      make_instruction();
      in_valid_i = 1'b1;
      do begin
        @(posedge clk);
        #1 wb_ready_i = pick_ready(i);
      end while (!in_xfer_seen);
    end
    in_valid_i = 1'b0;
    wb_ready_i = 1'b1;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    for (int idx = 0; idx < MEM_WORDS; idx++) begin
      check_value($sformatf("mem[%0d]", idx), mem[idx], model_mem[idx]);
    end
    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the instruction count with slack
  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired after %0d time units with work outstanding", WATCHDOG_TIME);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
mem_stage_pkg.sv
store_formatter.sv
load_formatter.sv
mem_access_ctrl.sv
mem_wb_reg.sv
mem_stage_top.sv
tb_clk_gen.sv
mem_stage_props.sv
mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_stage_tb \
  -f sources.f --Mdir obj_dir -o sim_mem_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
